/* src/chipBusPkg.sv */
// Chip bus bridge package holding bus widths, cycle state types and timing constants
package chipBusPkg;

    //////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////

    // Local bus address A[20:0]
    typedef logic [20:0] cpuAddr_t;
    // Multiplexed chip RAM address CMA
    typedef logic [10:0] dramAddr_t;
    // Agnus DRAM address DRA
    typedef logic [9:0]  dmaAddr_t;
    // 68040 SIZ code
    typedef logic [1:0]  xferSize_t;
    // Active low byte enables, upper lane in bit 3
    typedef logic [3:0]  laneMask_t;

    // SIZ encodings
    localparam xferSize_t SIZ_LONG = 2'd0;
    localparam xferSize_t SIZ_BYTE = 2'd1;
    localparam xferSize_t SIZ_WORD = 2'd2;
    localparam xferSize_t SIZ_LINE = 2'd3;

    //////////////////////////////////////////////////
    // Chipset phase and cycle states
    //////////////////////////////////////////////////

    // Phase as seen on {C1, C3}
    typedef enum logic [1:0] {
        PH_BOTH_LOW  = 2'b00,
        PH_C3_ONLY   = 2'b01,
        PH_C1_ONLY   = 2'b10,
        PH_BOTH_HIGH = 2'b11
    } chipPhase_t;

    // S2 slot, address strobe may start here
    localparam chipPhase_t ADDR_PHASE = PH_C1_ONLY;

    typedef enum logic [2:0] {REG_IDLE, REG_WAIT, REG_ADDR, REG_DATA, REG_END} regState_t;
    typedef enum logic [2:0] {RAM_IDLE, RAM_RAS, RAM_CAS, RAM_HOLD, RAM_END} ramState_t;

    // CLK80 cycles in RAS and CAS states
    localparam int RAS_CYCLES      = 2;
    localparam int CAS_CYCLES      = 2;
    // DBRn synchronizer depth
    localparam int DBR_SYNC_STAGES = 2;

    // Counter wide enough for the longer of the two
    localparam int RAM_CNT_W = $clog2(RAS_CYCLES > CAS_CYCLES ? RAS_CYCLES : CAS_CYCLES) + 1;
    typedef logic [RAM_CNT_W-1:0] ramCnt_t;

endpackage

/* src/cycleStatusIf.sv */
// Cycle status bundle shared by the cycle engines, termination and lane logic
interface cycleStatusIf;

    // Register cycle owns the chipset bus
    logic regCycle;
    // CPU chip RAM cycle in progress
    logic cpuCycle;
    // Agnus owns chip RAM
    logic dmaCycle;
    // Data strobe window of a register cycle
    logic dsEn;
    // Termination requests, one cycle each
    logic regTack;
    logic cpuTack;

    // Register cycle engine
    modport regCyc (output regCycle, dsEn, regTack);
    // Chip RAM engine
    modport ram (output cpuCycle, dmaCycle, cpuTack);
    // TACKn generator
    modport term (input regTack, cpuTack);
    // Byte lanes and buffers
    modport lanes (input regCycle, cpuCycle, dmaCycle, dsEn);

endinterface

/* src/regCycle.sv */
// Chipset register access engine, runs a 68000 style AS/DS cycle locked to C1/C3
module regCycle
    import chipBusPkg::*;
(
    input  logic CLK80,
    input  logic RESETn,
    input  logic C1,
    input  logic C3,
    input  logic TSn,
    input  logic REGSPACEn,
    input  logic dbrSync,
    output logic ASn,
    output logic REGENn,
    cycleStatusIf.regCyc status
);

    regState_t  state;
    regState_t  nextState;
    chipPhase_t phase;
    logic       regStart;

    assign phase = chipPhase_t'({C1, C3});

    // CPU transfer start into register space
    assign regStart = !TSn && !REGSPACEn;

    //////////////////////////////////////////////////
    // Cycle FSM
    //////////////////////////////////////////////////

    always_comb begin
        nextState = state;
        case (state)
            REG_IDLE: begin
                if (regStart) begin
                    nextState = REG_WAIT;
                end
            end
            // Hold off while Agnus has the bus, then wait for S2
            REG_WAIT: begin
                if (dbrSync && phase == ADDR_PHASE) begin
                    nextState = REG_ADDR;
                end
            end
            // One clock of address setup before the strobes
            REG_ADDR: nextState = REG_DATA;
            // Chipset latches data when C3 goes high
            REG_DATA: begin
                if (C3) begin
                    nextState = REG_END;
                end
            end
            REG_END:  nextState = REG_IDLE;
            default:  nextState = REG_IDLE;
        endcase
    end

    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            state <= REG_IDLE;
        end else begin
            state <= nextState;
        end
    end

    //////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////

    // AS and register buffer enable share the same window
    assign ASn    = !(state inside {REG_ADDR, REG_DATA});
    assign REGENn = ASn;

    // Bus is held from address phase until termination
    assign status.regCycle = state inside {REG_ADDR, REG_DATA, REG_END};
    assign status.dsEn     = (state == REG_DATA);
    assign status.regTack  = (state == REG_END);

    // Strobe only starts if the bus was free on the deciding edge
    property pAsNeedsBus;
        @(posedge CLK80) disable iff (!RESETn)
        ($fell(ASn) || $fell(REGENn)) |-> $past(dbrSync);
    endproperty
    aAsNeedsBus: assert property (pAsNeedsBus);

    // Single clock termination request
    property pRegTackOnce;
        @(posedge CLK80) disable iff (!RESETn)
        status.regTack |=> !status.regTack;
    endproperty
    aRegTackOnce: assert property (pRegTackOnce);

endmodule

/* src/chipRamCycle.sv */
// Chip RAM engine, CPU row/column DRAM cycles and Agnus DMA pass-through
module chipRamCycle
    import chipBusPkg::*;
(
    input  logic      CLK80,
    input  logic      RESETn,
    input  logic      TSn,
    input  logic      RAMSPACEn,
    input  logic      RnW,
    input  logic      AWEn,
    input  logic      RAS0n,
    input  logic      RAS1n,
    input  logic      CASLn,
    input  logic      CASUn,
    input  logic      dbrSync,
    input  cpuAddr_t  A,
    input  dmaAddr_t  DRA,
    output dramAddr_t CMA,
    output logic      BANK1,
    output logic      BANK0,
    output logic      CRCSn,
    output logic      RASn,
    output logic      CASn,
    output logic      WEn,
    output logic      DBENn,
    output logic      DBDIR,
    cycleStatusIf.ram status
);

    ramState_t state;
    ramState_t nextState;
    ramCnt_t   cnt;
    logic      ramStart;
    logic      reqPend;
    logic      cntDone;
    logic      rasAct;
    logic      casAct;
    logic      dmaCycle;
    dramAddr_t rowAddr;
    dramAddr_t colAddr;

    assign ramStart = !TSn && !RAMSPACEn;

    // Row from upper address, column from longword index
    assign rowAddr = A[20:10];
    assign colAddr = dramAddr_t'(A[9:2]);

    assign cntDone = (state == RAM_RAS) ? (cnt == ramCnt_t'(RAS_CYCLES - 1))
                                        : (cnt == ramCnt_t'(CAS_CYCLES - 1));

    //////////////////////////////////////////////////
    // CPU DRAM sequence
    //////////////////////////////////////////////////

    always_comb begin
        nextState = state;
        case (state)
            // Agnus has priority, a request waits in reqPend
            RAM_IDLE: begin
                if ((ramStart || reqPend) && dbrSync) begin
                    nextState = RAM_RAS;
                end
            end
            RAM_RAS:  if (cntDone) nextState = RAM_CAS;
            RAM_CAS:  if (cntDone) nextState = RAM_HOLD;
            RAM_HOLD: nextState = RAM_END;
            RAM_END:  nextState = RAM_IDLE;
            default:  nextState = RAM_IDLE;
        endcase
    end

    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            state   <= RAM_IDLE;
            cnt     <= '0;
            reqPend <= 1'b0;
        end else begin
            state <= nextState;
            // Counts clocks inside RAS and CAS only
            if (state != nextState || !(state inside {RAM_RAS, RAM_CAS})) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
            // Remember a start that arrived during DMA
            if (state == RAM_IDLE && nextState == RAM_RAS) begin
                reqPend <= 1'b0;
            end else if (ramStart) begin
                reqPend <= 1'b1;
            end
        end
    end

    // RAS held through CAS and hold
    assign rasAct = state inside {RAM_RAS, RAM_CAS, RAM_HOLD};
    assign casAct = state inside {RAM_CAS, RAM_HOLD};

    // Agnus owns RAM only between CPU cycles
    assign dmaCycle = !dbrSync && (state == RAM_IDLE);

    assign status.cpuCycle = (state != RAM_IDLE);
    assign status.dmaCycle = dmaCycle;
    assign status.cpuTack  = (state == RAM_HOLD);

    //////////////////////////////////////////////////
    // DRAM pin mux
    //////////////////////////////////////////////////

    always_comb begin
        if (dmaCycle) begin
            // Agnus timing straight through
            RASn  = RAS0n & RAS1n;
            CASn  = CASLn & CASUn;
            WEn   = AWEn;
            CMA   = dramAddr_t'(DRA);
            BANK0 = !RAS0n;
            BANK1 = !RAS1n;
        end else begin
            RASn  = !rasAct;
            CASn  = !casAct;
            WEn   = casAct ? RnW : 1'b1;
            CMA   = casAct ? colAddr : rowAddr;
            // Bank select from A20
            BANK1 = A[20];
            BANK0 = !A[20];
        end
    end

    // CPU side buffers, idle during DMA
    assign CRCSn = !rasAct;
    assign DBENn = !casAct;
    assign DBDIR = casAct && RnW;

    property pOneOwner;
        @(posedge CLK80) disable iff (!RESETn)
        !(status.cpuCycle && status.dmaCycle);
    endproperty
    aOneOwner: assert property (pOneOwner);

    // Fixed latency when the bus is free
    property pRamLatency;
        @(posedge CLK80) disable iff (!RESETn)
        (ramStart && dbrSync && state == RAM_IDLE)
            |-> ##(RAS_CYCLES + CAS_CYCLES + 1) status.cpuTack;
    endproperty
    aRamLatency: assert property (pRamLatency);

endmodule

/* src/cycleTerm.sv */
// Transfer termination, folds both engine requests into one TACKn pulse
module cycleTerm
    import chipBusPkg::*;
(
    input  logic CLK80,
    input  logic RESETn,
    output logic TACKn,
    cycleStatusIf.term status
);

    logic tackReq;
    logic reqSeen;

    assign tackReq = status.regTack || status.cpuTack;

    // Pulse on the first clock of a request only
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            TACKn   <= 1'b1;
            reqSeen <= 1'b0;
        end else begin
            reqSeen <= tackReq;
            TACKn   <= !(tackReq && !reqSeen);
        end
    end

    property pTackSingle;
        @(posedge CLK80) disable iff (!RESETn)
        !TACKn |=> TACKn;
    endproperty
    aTackSingle: assert property (pTackSingle);

    // Register and RAM engines never finish together
    property pNoDoubleReq;
        @(posedge CLK80) disable iff (!RESETn)
        !(status.regTack && status.cpuTack);
    endproperty
    aNoDoubleReq: assert property (pNoDoubleReq);

endmodule

/* src/laneControl.sv */
// Byte lane decode, chipset data strobes and data buffer control
module laneControl
    import chipBusPkg::*;
(
    input  logic       RESETn,
    input  logic       CLK80,
    input  logic       RnW,
    input  logic       AWEn,
    input  logic       CASLn,
    input  logic       CASUn,
    input  logic       DBENn,
    input  cpuAddr_t   A,
    input  xferSize_t  SIZ,
    output laneMask_t  laneEn,
    output logic       UDSn,
    output logic       LDSn,
    output logic       VBENn,
    output logic       DRDENn,
    output logic       DRDDIR,
    cycleStatusIf.lanes status
);

    laneMask_t cpuMask;
    logic      udsSel;
    logic      ldsSel;

    //////////////////////////////////////////////////
    // 68040 byte lanes
    //////////////////////////////////////////////////

    always_comb begin
        case (SIZ)
            // Single lane picked by A[1:0], lane 3 at offset 0
            SIZ_BYTE: cpuMask = ~(laneMask_t'(4'b1000) >> A[1:0]);
            // Upper or lower pair
            SIZ_WORD: cpuMask = A[1] ? laneMask_t'(4'b1100) : laneMask_t'(4'b0011);
            // Long and line, all four
            default:  cpuMask = '0;
        endcase
    end

    always_comb begin
        if (status.dmaCycle) begin
            // Agnus CAS per 16 bit half
            laneEn = {CASUn, CASUn, CASLn, CASLn};
        end else if (status.cpuCycle && !DBENn) begin
            laneEn = cpuMask;
        end else begin
            laneEn = '1;
        end
    end

    //////////////////////////////////////////////////
    // Register cycle strobes
    //////////////////////////////////////////////////

    // 16 bit chipset, even byte on UDS
    assign udsSel = (SIZ == SIZ_BYTE) ? !A[0] : 1'b1;
    assign ldsSel = (SIZ == SIZ_BYTE) ? A[0] : 1'b1;

    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            UDSn <= 1'b1;
            LDSn <= 1'b1;
        end else begin
            UDSn <= !(status.regCycle && status.dsEn && udsSel);
            LDSn <= !(status.regCycle && status.dsEn && ldsSel);
        end
    end

    // Buffer enables
    assign VBENn  = !status.regCycle;
    assign DRDENn = !status.dmaCycle;
    // Agnus write drives RAM, direction preset from RnW otherwise
    assign DRDDIR = status.dmaCycle ? !AWEn : (status.regCycle && RnW);

endmodule

/* src/chipBusTop.sv */
// Chip bus bridge top level with the DBRn synchronizer and block interconnect
module chipBusTop
    import chipBusPkg::*;
(
    input  logic      CLK80,
    input  logic      RESETn,
    input  logic      C1,
    input  logic      C3,
    input  logic      RnW,
    input  logic      TSn,
    input  logic      DBRn,
    input  logic      REGSPACEn,
    input  logic      RAMSPACEn,
    input  logic      AWEn,
    input  logic      RAS0n,
    input  logic      RAS1n,
    input  logic      CASLn,
    input  logic      CASUn,
    input  xferSize_t SIZ,
    input  cpuAddr_t  A,
    input  dmaAddr_t  DRA,
    output logic      LDSn,
    output logic      UDSn,
    output logic      ASn,
    output logic      REGENn,
    output logic      DBDIR,
    output logic      VBENn,
    output logic      DRDENn,
    output logic      DRDDIR,
    output logic      CRCSn,
    output logic      BANK1,
    output logic      BANK0,
    output logic      RASn,
    output logic      CASn,
    output logic      WEn,
    output logic      DBENn,
    output dramAddr_t CMA,
    output logic      CUUBEn,
    output logic      CUMBEn,
    output logic      CLMBEn,
    output logic      CLLBEn,
    output logic      TACKn
);

    //////////////////////////////////////////////////
    // DBRn synchronizer
    //////////////////////////////////////////////////

    logic [DBR_SYNC_STAGES-1:0] dbrPipe;
    logic                       dbrSync;
    laneMask_t                  laneEn;

    // Idles high, Agnus not requesting
    always_ff @(posedge CLK80) begin
        if (!RESETn) begin
            dbrPipe <= '1;
        end else begin
            dbrPipe <= {dbrPipe[DBR_SYNC_STAGES-2:0], DBRn};
        end
    end

    assign dbrSync = dbrPipe[DBR_SYNC_STAGES-1];

    //////////////////////////////////////////////////
    // Cycle engines and lanes
    //////////////////////////////////////////////////

    cycleStatusIf cycStat ();

    regCycle uRegCycle (
        .CLK80(CLK80), .RESETn(RESETn), .C1(C1), .C3(C3), .TSn(TSn),
        .REGSPACEn(REGSPACEn), .dbrSync(dbrSync), .ASn(ASn), .REGENn(REGENn),
        .status(cycStat.regCyc)
    );

    chipRamCycle uChipRamCycle (
        .CLK80(CLK80), .RESETn(RESETn), .TSn(TSn), .RAMSPACEn(RAMSPACEn),
        .RnW(RnW), .AWEn(AWEn), .RAS0n(RAS0n), .RAS1n(RAS1n), .CASLn(CASLn),
        .CASUn(CASUn), .dbrSync(dbrSync), .A(A), .DRA(DRA), .CMA(CMA),
        .BANK1(BANK1), .BANK0(BANK0), .CRCSn(CRCSn), .RASn(RASn), .CASn(CASn),
        .WEn(WEn), .DBENn(DBENn), .DBDIR(DBDIR), .status(cycStat.ram)
    );

    cycleTerm uCycleTerm (
        .CLK80(CLK80), .RESETn(RESETn), .TACKn(TACKn), .status(cycStat.term)
    );

    laneControl uLaneControl (
        .RESETn(RESETn), .CLK80(CLK80), .RnW(RnW), .AWEn(AWEn), .CASLn(CASLn),
        .CASUn(CASUn), .DBENn(DBENn), .A(A), .SIZ(SIZ), .laneEn(laneEn),
        .UDSn(UDSn), .LDSn(LDSn), .VBENn(VBENn), .DRDENn(DRDENn), .DRDDIR(DRDDIR),
        .status(cycStat.lanes)
    );

    // Upper lane first
    assign CUUBEn = laneEn[3];
    assign CUMBEn = laneEn[2];
    assign CLMBEn = laneEn[1];
    assign CLLBEn = laneEn[0];

endmodule

/* verification/chipBusTb.sv */
// Chip bus bridge testbench with random CPU and DMA traffic checked against a reference model
module chipBusTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT  = 100;
    // Edge that samples TSn counts as cycle 2
    localparam int RAM_LATENCY = 7;
    localparam int OPERATIONS  = 80;

    //////////////////////////////////////////////////
    // DUT pins
    //////////////////////////////////////////////////

    logic        CLK80;
    logic        RESETn;
    logic        C1 = 1'b0;
    logic        C3 = 1'b0;
    logic        RnW, TSn, DBRn, REGSPACEn, RAMSPACEn;
    logic        AWEn, RAS0n, RAS1n, CASLn, CASUn;
    logic [1:0]  SIZ;
    logic [20:0] A;
    logic [9:0]  DRA;
    logic        LDSn, UDSn, ASn, REGENn, DBDIR, VBENn, DRDENn, DRDDIR;
    logic        CRCSn, BANK1, BANK0, RASn, CASn, WEn, DBENn, TACKn;
    logic [10:0] CMA;
    logic        CUUBEn, CUMBEn, CLMBEn, CLLBEn;
    logic [3:0]  lanes;

    // Model and bookkeeping
    logic [2:0]  phCnt = 3'd0;
    logic [1:0]  syncPipe = 2'b11;
    logic        syncModel;
    logic        tackWasLow = 1'b0;
    logic [31:0] rngState;
    int          errCount = 0;
    int          checkCount = 0;
    int          tackCount = 0;
    int          dmaLeft = 0;

    // Upper lane first
    assign lanes = {CUUBEn, CUMBEn, CLMBEn, CLLBEn};

    chipBusTop dut_i (.*);

    initial begin
        CLK80 = 1'b0;
        forever #20 CLK80 = ~CLK80;
    end

    // Quadrature chipset phases, 8 clock period
    always @(posedge CLK80) begin
        phCnt <= phCnt + 3'd1;
        C1    <= (phCnt < 3'd4);
        C3    <= (phCnt >= 3'd2) && (phCnt < 3'd6);
    end

    // Two stage DBRn synchronizer model
    always @(posedge CLK80) begin
        if (!RESETn) begin
            syncPipe <= 2'b11;
        end else begin
            syncPipe <= {syncPipe[0], DBRn};
        end
    end
    assign syncModel = syncPipe[1];

    //////////////////////////////////////////////////
    // Checks and helpers
    //////////////////////////////////////////////////

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            errCount++;
            $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic checkTrue(input logic cond, input string what);
        checkCount++;
        assert (cond) else begin
            errCount++;
            $display("Failure at %0t ns: %s", $time, what);
        end
    endtask

    // Every TACKn pulse counted, width one cycle
    always @(negedge CLK80) begin
        if (RESETn) begin
            if (!TACKn) begin
                tackCount++;
            end
            checkTrue(!(tackWasLow && !TACKn), "TACKn held low for more than one cycle");
            tackWasLow = !TACKn;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    // 68040 byte enables, active low, upper lane first
    function automatic logic [3:0] laneTable(input logic [1:0] siz, input logic [1:0] off);
        logic [3:0] m;
        case (siz)
            2'd1: begin
                case (off)
                    2'd0:    m = 4'b0111;
                    2'd1:    m = 4'b1011;
                    2'd2:    m = 4'b1101;
                    default: m = 4'b1110;
                endcase
            end
            2'd2:    m = off[1] ? 4'b1100 : 4'b0011;
            default: m = 4'b0000;
        endcase
        return m;
    endfunction

    // Agnus side, random strobes while a burst lasts
    task automatic driveDma();
        logic [31:0] r;
        if (dmaLeft > 0) begin
            r = nextRand();
            DBRn  <= 1'b0;
            RAS0n <= r[0];
            RAS1n <= r[1];
            CASLn <= r[2];
            CASUn <= r[3];
            AWEn  <= r[4];
            DRA   <= r[14:5];
            dmaLeft--;
        end else begin
            DBRn  <= 1'b1;
            RAS0n <= 1'b1;
            RAS1n <= 1'b1;
            CASLn <= 1'b1;
            CASUn <= 1'b1;
            AWEn  <= 1'b1;
        end
    endtask

    // Pass-through of Agnus control while it owns the RAM
    task automatic checkDma();
        checkValue("RASn", RASn, RAS0n & RAS1n);
        checkValue("CASn", CASn, CASLn & CASUn);
        checkValue("WEn", WEn, AWEn);
        checkValue("CMA", CMA, {1'b0, DRA});
        checkValue("BANK0", BANK0, !RAS0n);
        checkValue("BANK1", BANK1, !RAS1n);
        checkValue("byte enables", lanes, {CASUn, CASUn, CASLn, CASLn});
        checkValue("DRDENn", DRDENn, 1'b0);
        checkValue("DRDDIR", DRDDIR, !AWEn);
        checkValue("TACKn", TACKn, 1'b1);
    endtask

    task automatic checkIdle();
        checkValue("ASn", ASn, 1'b1);
        checkValue("REGENn", REGENn, 1'b1);
        checkValue("RASn", RASn, 1'b1);
        checkValue("CASn", CASn, 1'b1);
        checkValue("WEn", WEn, 1'b1);
        checkValue("CRCSn", CRCSn, 1'b1);
        checkValue("DBENn", DBENn, 1'b1);
        checkValue("TACKn", TACKn, 1'b1);
        checkValue("UDSn", UDSn, 1'b1);
        checkValue("LDSn", LDSn, 1'b1);
        checkValue("VBENn", VBENn, 1'b1);
        checkValue("DRDENn", DRDENn, 1'b1);
        checkValue("byte enables", lanes, 4'hf);
        checkValue("DRDDIR", DRDDIR, 1'b0);
        checkValue("DBDIR", DBDIR, 1'b0);
    endtask

    // One clock, strobes released, outputs sampled mid cycle
    task automatic stepClock();
        @(posedge CLK80);
        TSn       <= 1'b1;
        REGSPACEn <= 1'b1;
        RAMSPACEn <= 1'b1;
        driveDma();
        @(negedge CLK80);
        if (!syncModel) begin
            checkDma();
        end
    endtask

    task automatic issueTransfer(input logic toReg, input logic [20:0] addr, input logic rnw,
                                 input logic [1:0] siz);
        @(posedge CLK80);
        TSn       <= 1'b0;
        REGSPACEn <= !toReg;
        RAMSPACEn <= toReg;
        A         <= addr;
        RnW       <= rnw;
        SIZ       <= siz;
        driveDma();
        @(negedge CLK80);
        if (!syncModel) begin
            checkDma();
        end
    endtask

    //////////////////////////////////////////////////
    // Chip RAM transfer
    //////////////////////////////////////////////////

    task automatic checkRamPins(input logic [20:0] addr, input logic rnw, input logic [1:0] siz);
        checkValue("BANK1", BANK1, addr[20]);
        checkValue("BANK0", BANK0, !addr[20]);
        checkValue("DRDENn", DRDENn, 1'b1);
        checkValue("CRCSn", CRCSn, RASn);
        if (!CASn) begin
            // Column phase
            checkValue("RASn", RASn, 1'b0);
            checkValue("CMA column", CMA, {3'b000, addr[9:2]});
            checkValue("WEn", WEn, rnw);
            checkValue("DBENn", DBENn, 1'b0);
            checkValue("DBDIR", DBDIR, rnw);
            checkValue("byte enables", lanes, laneTable(siz, addr[1:0]));
        end else begin
            checkValue("WEn", WEn, 1'b1);
            checkValue("DBENn", DBENn, 1'b1);
            checkValue("byte enables", lanes, 4'hf);
            if (!RASn) begin
                checkValue("CMA row", CMA, addr[20:10]);
            end
        end
    endtask

    task automatic ramTransfer(input logic [20:0] addr, input logic rnw, input logic [1:0] siz);
        int   cyc;
        int   rasOnly;
        int   casLow;
        int   tackStart;
        logic direct;
        // Bus free on the sampling edge, fixed latency expected
        direct    = syncModel && (dmaLeft == 0);
        tackStart = tackCount;
        rasOnly   = 0;
        casLow    = 0;
        issueTransfer(1'b0, addr, rnw, siz);
        cyc = 1;
        while (TACKn && cyc < WAIT_LIMIT) begin
            stepClock();
            cyc++;
            if (syncModel) begin
                checkRamPins(addr, rnw, siz);
                if (!RASn && CASn) begin
                    rasOnly++;
                end
                if (!CASn) begin
                    casLow++;
                end
            end
        end
        checkTrue(!TACKn, "timeout waiting for TACKn of a chip RAM transfer");
        if (direct) begin
            checkValue("RAM latency", cyc, RAM_LATENCY);
        end
        checkValue("RAS only cycles", rasOnly, 2);
        checkValue("CAS cycles", casLow, 3);
        checkValue("DBRn at RAM completion", DBRn, 1'b1);
        stepClock();
        stepClock();
        checkValue("TACKn pulses", tackCount - tackStart, 1);
    endtask

    //////////////////////////////////////////////////
    // Chipset register transfer
    //////////////////////////////////////////////////

    task automatic regTransfer(input logic [20:0] addr, input logic rnw, input logic [1:0] siz);
        int   cyc;
        int   tackStart;
        logic asWasLow;
        logic syncBefore;
        logic dbrBefore;
        logic c1Before;
        logic c3Before;
        logic dsSeen;
        logic udsExp;
        logic ldsExp;
        // Expected strobe levels, even byte on UDS
        udsExp    = (siz == 2'd1) ? addr[0] : 1'b0;
        ldsExp    = (siz == 2'd1) ? !addr[0] : 1'b0;
        tackStart = tackCount;
        asWasLow  = 1'b0;
        dsSeen    = 1'b0;
        issueTransfer(1'b1, addr, rnw, siz);
        cyc = 1;
        while (TACKn && cyc < WAIT_LIMIT) begin
            // Levels seen by the deciding edge
            syncBefore = syncModel;
            dbrBefore  = DBRn;
            c1Before   = C1;
            c3Before   = C3;
            stepClock();
            cyc++;
            checkValue("REGENn", REGENn, ASn);
            if (!ASn && !asWasLow) begin
                checkTrue(syncBefore && dbrBefore, "ASn fell while Agnus held the bus");
                checkTrue(c1Before && !c3Before, "ASn fell outside the S2 chipset slot");
            end
            if (!ASn) begin
                checkValue("VBENn", VBENn, 1'b0);
            end
            if (!UDSn || !LDSn) begin
                dsSeen = 1'b1;
                checkValue("UDSn", UDSn, udsExp);
                checkValue("LDSn", LDSn, ldsExp);
                checkValue("VBENn", VBENn, 1'b0);
            end
            if (syncModel) begin
                checkValue("CRCSn", CRCSn, 1'b1);
            end
            asWasLow = !ASn;
        end
        checkTrue(!TACKn, "timeout waiting for TACKn of a register transfer");
        checkTrue(dsSeen, "register transfer ended without a data strobe");
        stepClock();
        stepClock();
        checkValue("TACKn pulses", tackCount - tackStart, 1);
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        logic [31:0] addrRand;
        int          gap;
        rngState  = 32'd60724;
        RESETn    = 1'b0;
        TSn       = 1'b1;
        REGSPACEn = 1'b1;
        RAMSPACEn = 1'b1;
        RnW       = 1'b1;
        SIZ       = 2'd0;
        A         = '0;
        DBRn      = 1'b1;
        AWEn      = 1'b1;
        RAS0n     = 1'b1;
        RAS1n     = 1'b1;
        CASLn     = 1'b1;
        CASUn     = 1'b1;
        DRA       = '0;
        repeat (5) @(posedge CLK80);
        RESETn <= 1'b1;

        // Quiet bus after reset
        repeat (8) begin
            stepClock();
            checkIdle();
        end

        for (int i = 0; i < OPERATIONS; i++) begin
            r        = nextRand();
            addrRand = nextRand();
            case (r[1:0])
                2'd0, 2'd1: ramTransfer(addrRand[20:0], r[2], r[4:3]);
                // Byte or word only on the 16 bit chipset
                2'd2:       regTransfer(addrRand[20:0], r[2], {r[3], !r[3]});
                default: begin
                    dmaLeft = 4 + int'(r[7:5]);
                    repeat (3) stepClock();
                    // Optional CPU request parked behind the burst
                    case (r[9:8])
                        2'd1, 2'd3: ramTransfer(addrRand[20:0], r[2], r[4:3]);
                        2'd2:       regTransfer(addrRand[20:0], r[2], {r[3], !r[3]});
                        default:    ;
                    endcase
                    for (int k = 0; k < WAIT_LIMIT && dmaLeft > 0; k++) begin
                        stepClock();
                    end
                    checkTrue(dmaLeft == 0, "timeout waiting for the DMA burst to end");
                    repeat (3) stepClock();
                end
            endcase
            gap = 1 + int'(r[12:10]);
            repeat (gap) begin
                stepClock();
                checkIdle();
            end
        end

        $display("Checks run: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* filelist.f */
src/chipBusPkg.sv
src/cycleStatusIf.sv
src/regCycle.sv
src/chipRamCycle.sv
src/cycleTerm.sv
src/laneControl.sv
src/chipBusTop.sv
verification/chipBusTb.sv

/* run.sh */
#!/bin/sh
# Build and run the chip bus bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    -f filelist.f --top-module chipBusTb -Mdir obj_dir -o simChipBus

./obj_dir/simChipBus | tee sim.log

if grep -q "All tests passed!" sim.log; then
    echo "simulation PASSED"
else
    echo "simulation FAILED"
    exit 1
fi
